/* compile.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/stageReg.sv
verilog/regFile.sv
verilog/decoder.sv
verilog/alu.sv
verilog/hazardUnit.sv
verilog/pipeCpu.sv
dv/pipeCpu_sva.sv
dv/pipeCpuTb.sv

/* dv/pipeCpuTb.sv */
/*
 * Testbench for the pipelined MIPS core
 * Models both memories, runs directed and random programs and checks
 * every store and load address against an instruction-level reference model
 */

module pipeCpuTb;

    logic          clk = 1'b0;
    logic          arstN;
    isaPkg::word_t pc;
    isaPkg::word_t inst;
    isaPkg::word_t dataAddress;
    isaPkg::word_t writeData;
    isaPkg::word_t readData;
    logic          memRead;
    logic          memWrite;

    isaPkg::word_t imem [256];
    isaPkg::word_t dmem [256];
    isaPkg::word_t prog [$];
    isaPkg::word_t expAddr [$];
    isaPkg::word_t expData [$];
    isaPkg::word_t expLoadAddr [$];

    integer seed = 32'hf15;
    int     cycleCount = 0;
    int     startCycle = 0;
    int     cycleLimit = 0;
    logic   running = 1'b0;

    always #4 clk = ~clk;

    pipeCpu dut (
        .clk         (clk),
        .arstN       (arstN),
        .pc          (pc),
        .inst        (inst),
        .dataAddress (dataAddress),
        .writeData   (writeData),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .readData    (readData)
    );

    // ------------------------------------------------------------------------
    // Memories
    // ------------------------------------------------------------------------
    function automatic isaPkg::word_t memFill(int idx);
        return isaPkg::word_t'(idx) * 32'h9e37_79b1 + 32'h0102_0304;
    endfunction

    assign inst     = imem[pc[9:2]];
    assign readData = dmem[dataAddress[9:2]];

    always @(posedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= memFill(i);
            end
        end else if (memWrite) begin
            dmem[dataAddress[9:2]] <= writeData;
        end
    end

    // ------------------------------------------------------------------------
    // Encoding helpers
    // ------------------------------------------------------------------------
    function automatic isaPkg::word_t encR(isaPkg::funct_t fn, int rd, int rs, int rt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    function automatic isaPkg::word_t encI(isaPkg::opcode_t op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic isaPkg::word_t encJ(int idx);
        return {isaPkg::J, 26'(idx)};
    endfunction

    function automatic void emit(isaPkg::word_t w);
        prog.push_back(w);
    endfunction

    function automatic void storeRegs(int first, int last, int base);
        for (int r = first; r <= last; r++) begin
            emit(encI(isaPkg::SW, r, 0, base + 4 * r));
        end
    endfunction

    // Program ends in a j to itself
    function automatic void closeWithLoop();
        emit(encJ(prog.size()));
    endfunction

    function automatic int pick(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // ------------------------------------------------------------------------
    // Reference model that steps one instruction at a time
    // ------------------------------------------------------------------------
    function automatic int refRun(output isaPkg::word_t endPc);
        isaPkg::word_t   regs [32];
        isaPkg::word_t   mem [256];
        isaPkg::word_t   pcR;
        isaPkg::word_t   npc;
        isaPkg::word_t   w;
        isaPkg::word_t   a;
        isaPkg::word_t   b;
        isaPkg::word_t   sext;
        isaPkg::word_t   addr;
        isaPkg::regIdx_t rt;
        isaPkg::regIdx_t rd;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = memFill(i);
        end
        expAddr.delete();
        expData.delete();
        expLoadAddr.delete();
        pcR   = '0;
        endPc = '0;
        for (int steps = 1; steps <= 2000; steps++) begin
            w    = imem[pcR[9:2]];
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            rt   = w[20:16];
            rd   = w[15:11];
            sext = {{16{w[15]}}, w[15:0]};
            addr = a + sext;
            npc  = pcR + 32'd4;
            case (isaPkg::opcode_t'(w[31:26]))
                isaPkg::RTYPE: begin
                    case (isaPkg::funct_t'(w[5:0]))
                        isaPkg::ADDU: regs[rd] = a + b;
                        isaPkg::SUBU: regs[rd] = a - b;
                        isaPkg::AND:  regs[rd] = a & b;
                        isaPkg::OR:   regs[rd] = a | b;
                        isaPkg::SLT:  regs[rd] = {31'b0, $signed(a) < $signed(b)};
                        isaPkg::JR:   npc = a;
                        default: ;
                    endcase
                end
                isaPkg::ADDIU: regs[rt] = addr;
                isaPkg::ANDI:  regs[rt] = a & {16'h0000, w[15:0]};
                isaPkg::ORI:   regs[rt] = a | {16'h0000, w[15:0]};
                isaPkg::LUI:   regs[rt] = {w[15:0], 16'h0000};
                isaPkg::LW: begin
                    regs[rt] = mem[addr[9:2]];
                    expLoadAddr.push_back(addr);
                end
                isaPkg::SW: begin
                    mem[addr[9:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                isaPkg::BEQ: if (a == b) npc = pcR + 32'd4 + (sext << 2);
                isaPkg::BNE: if (a != b) npc = pcR + 32'd4 + (sext << 2);
                isaPkg::J: begin
                    npc = {npc[31:28], w[25:0], 2'b00};
                    if (npc == pcR) begin
                        endPc = pcR;
                        return steps;
                    end
                end
                default: ;
            endcase
            regs[0] = '0;
            pcR     = npc;
        end
        return -1;
    endfunction

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic failRun(string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkAddr(isaPkg::word_t got, isaPkg::word_t exp);
        if (got !== exp) begin
            failRun($sformatf("error at %0t: data address %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic checkData(isaPkg::word_t got, isaPkg::word_t exp);
        if (got !== exp) begin
            failRun($sformatf("error at %0t: store data %h, expected %h", $time, got, exp));
        end
    endtask

    always @(posedge clk) begin
        if (arstN && memWrite) begin
            if (expAddr.size() == 0) begin
                failRun($sformatf("store of %h to address %h came after all expected stores",
                                  writeData, dataAddress));
            end else begin
                checkAddr(dataAddress, expAddr.pop_front());
                checkData(writeData, expData.pop_front());
            end
        end
        if (arstN && memRead) begin
            if (expLoadAddr.size() == 0) begin
                failRun($sformatf("load from address %h came after all expected loads",
                                  dataAddress));
            end else begin
                checkAddr(dataAddress, expLoadAddr.pop_front());
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (running && cycleCount - startCycle > cycleLimit) begin
            failRun($sformatf("timeout: program did not finish within %0d cycles",
                              cycleLimit));
        end
    end

    // ------------------------------------------------------------------------
    // Program runs
    // ------------------------------------------------------------------------
    task automatic runProgram(string name);
        isaPkg::word_t endPc;
        int            n;
        @(negedge clk);
        arstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        n = refRun(endPc);
        if (n < 0) begin
            failRun($sformatf("reference model never reached the end loop of %s", name));
        end else begin
            repeat (10) @(negedge clk);
            arstN      = 1'b1;
            startCycle = cycleCount;
            cycleLimit = 4 * n + 50;
            running    = 1'b1;
            while (expAddr.size() != 0 || expLoadAddr.size() != 0 || pc != endPc) begin
                @(negedge clk);
            end
            // Let the pipeline drain so a stray store still shows up
            repeat (5) @(negedge clk);
            running = 1'b0;
        end
    endtask

    task automatic makeRandomProgram();
        int rd;
        int rs;
        int rt;
        int off;
        prog.delete();
        for (int r = 1; r < 5; r++) begin
            emit(encI(isaPkg::ADDIU, r, 0, pick(65536)));
        end
        for (int i = 0; i < 40; i++) begin
            rd  = pick(5);
            rs  = pick(5);
            rt  = pick(5);
            off = 4 * pick(64);
            case (pick(11))
                0:       emit(encR(isaPkg::ADDU, rd, rs, rt));
                1:       emit(encR(isaPkg::SUBU, rd, rs, rt));
                2:       emit(encR(isaPkg::AND, rd, rs, rt));
                3:       emit(encR(isaPkg::OR, rd, rs, rt));
                4:       emit(encR(isaPkg::SLT, rd, rs, rt));
                5:       emit(encI(isaPkg::ADDIU, rd, rs, pick(65536)));
                6:       emit(encI(isaPkg::ANDI, rd, rs, pick(65536)));
                7:       emit(encI(isaPkg::ORI, rd, rs, pick(65536)));
                8:       emit(encI(isaPkg::LUI, rd, 0, pick(65536)));
                9:       emit(encI(isaPkg::LW, rd, 0, off));
                default: emit(encI(isaPkg::SW, rt, 0, off));
            endcase
        end
        storeRegs(1, 4, 240);
        closeWithLoop();
    endtask

    initial begin
        arstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end

        // ALU results with sign and zero extension
        prog.delete();
        emit(encI(isaPkg::LUI, 1, 0, 'h8001));
        emit(encI(isaPkg::ORI, 1, 1, 'hf00f));
        emit(encI(isaPkg::ADDIU, 2, 0, 'hfffb));
        emit(encI(isaPkg::ANDI, 3, 2, 'hff00));
        emit(encR(isaPkg::SLT, 4, 2, 0));
        emit(encR(isaPkg::SLT, 5, 0, 2));
        emit(encR(isaPkg::SLT, 6, 1, 2));
        emit(encR(isaPkg::ADDU, 7, 1, 2));
        emit(encR(isaPkg::SUBU, 8, 2, 1));
        emit(encR(isaPkg::AND, 9, 1, 3));
        emit(encR(isaPkg::OR, 10, 2, 4));
        emit(encI(isaPkg::ADDIU, 11, 1, 'h7fff));
        storeRegs(0, 11, 0);
        closeWithLoop();
        runProgram("alu");

        // Forwarding at distance 1, 2 and 3 and writes to $0
        prog.delete();
        emit(encI(isaPkg::ADDIU, 1, 0, 7));
        emit(encR(isaPkg::ADDU, 2, 1, 1));
        emit(encR(isaPkg::SUBU, 3, 2, 1));
        emit(encI(isaPkg::ADDIU, 0, 1, 99));
        emit(encR(isaPkg::OR, 4, 0, 3));
        emit(encR(isaPkg::ADDU, 0, 4, 4));
        emit(encR(isaPkg::ADDU, 5, 0, 1));
        emit(encI(isaPkg::ADDIU, 7, 0, 3));
        emit(encI(isaPkg::ADDIU, 8, 0, 1));
        emit(encI(isaPkg::ADDIU, 9, 0, 2));
        emit(encR(isaPkg::ADDU, 10, 7, 0));
        emit(encI(isaPkg::ADDIU, 11, 0, 'h55));
        emit(encI(isaPkg::SW, 11, 0, 100));
        emit(encI(isaPkg::ADDIU, 12, 0, 64));
        emit(encI(isaPkg::SW, 12, 12, 0));
        storeRegs(0, 12, 128);
        closeWithLoop();
        runProgram("forwarding");

        // Load followed at once by a use
        prog.delete();
        emit(encI(isaPkg::LW, 1, 0, 8));
        emit(encR(isaPkg::ADDU, 2, 1, 1));
        emit(encI(isaPkg::LW, 3, 0, 12));
        emit(encI(isaPkg::SW, 3, 0, 200));
        emit(encI(isaPkg::LW, 4, 0, 16));
        emit(encI(isaPkg::ADDIU, 5, 4, 1));
        emit(encI(isaPkg::ADDIU, 6, 0, 32));
        emit(encI(isaPkg::LW, 7, 6, 0));
        emit(encI(isaPkg::SW, 6, 0, 40));
        emit(encI(isaPkg::LW, 9, 0, 40));
        emit(encI(isaPkg::LW, 10, 9, 0));
        storeRegs(1, 10, 128);
        closeWithLoop();
        runProgram("load-use");

        // Branches, j and jr; wrong-path stores must not appear
        prog.delete();
        emit(encI(isaPkg::ADDIU, 1, 0, 5));
        emit(encI(isaPkg::ADDIU, 2, 0, 5));
        emit(encI(isaPkg::BEQ, 2, 1, 2));
        emit(encI(isaPkg::SW, 1, 0, 0));
        emit(encI(isaPkg::SW, 2, 0, 4));
        emit(encI(isaPkg::BNE, 2, 1, 1));
        emit(encI(isaPkg::SW, 1, 0, 8));
        emit(encI(isaPkg::ADDIU, 3, 0, 1));
        emit(encI(isaPkg::BNE, 3, 1, 2));
        emit(encI(isaPkg::SW, 3, 0, 12));
        emit(encI(isaPkg::SW, 3, 0, 16));
        emit(encI(isaPkg::BEQ, 3, 1, 1));
        emit(encI(isaPkg::SW, 3, 0, 20));
        emit(encJ(16));
        emit(encI(isaPkg::SW, 1, 0, 24));
        emit(encI(isaPkg::SW, 1, 0, 28));
        emit(encI(isaPkg::ADDIU, 4, 0, 84));
        emit(encR(isaPkg::JR, 0, 4, 0));
        emit(encI(isaPkg::SW, 4, 0, 32));
        emit(encI(isaPkg::SW, 4, 0, 36));
        emit(encI(isaPkg::SW, 4, 0, 40));
        emit(encI(isaPkg::SW, 4, 0, 44));
        emit(encI(isaPkg::LW, 5, 0, 44));
        emit(encI(isaPkg::BEQ, 4, 5, 1));
        emit(encI(isaPkg::SW, 5, 0, 48));
        emit(encI(isaPkg::SW, 5, 0, 52));
        emit(encI(isaPkg::ADDIU, 6, 0, 3));
        emit(encI(isaPkg::ADDIU, 6, 6, 'hffff));
        emit(encI(isaPkg::SW, 6, 0, 56));
        emit(encI(isaPkg::BNE, 0, 6, 'hfffd));
        closeWithLoop();
        runProgram("control flow");

        for (int p = 0; p < 20; p++) begin
            makeRandomProgram();
            runProgram($sformatf("random program %0d", p));
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* dv/pipeCpu_sva.sv */
/*
 * Assertions for the pipelined MIPS core
 * Data memory strobes and fetch alignment
 */

module pipeCpuSva (
    input logic          clk,
    input logic          arstN,
    input isaPkg::word_t pc,
    input logic          memRead,
    input logic          memWrite
);

    // One word access per instruction in MEM
    strobeExclusive: assert property (
        @(posedge clk) disable iff (!arstN) !(memRead && memWrite)
    ) else $error("memRead and memWrite are high in the same cycle");

    // Pipeline leaves reset full of bubbles
    idleAfterReset: assert property (
        @(posedge clk) $rose(arstN) |-> (!memRead && !memWrite)
    ) else $error("memory strobe high in the first cycle after reset");

    pcAligned: assert property (
        @(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00
    ) else $error("pc %h is not word aligned", pc);

endmodule

bind pipeCpu pipeCpuSva sva (
    .clk      (clk),
    .arstN    (arstN),
    .pc       (pc),
    .memRead  (memRead),
    .memWrite (memWrite)
);

/* run.sh */
#!/bin/sh
# Build and run the pipelined MIPS core testbench with Verilator.
# A failing check ends the run with $fatal, so the exit status carries the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module pipeCpuTb \
    -o pipeCpuTb

./obj_dir/pipeCpuTb

/* verilog/alu.sv */
/*
 * 32-bit ALU
 * add, sub, and, or, signed slt and lui, with a zero flag for branches
 */

module alu (
    input  isaPkg::word_t   opA,
    input  isaPkg::word_t   opB,
    input  pipePkg::aluOp_t aluOp,
    output isaPkg::word_t   result,
    output logic            zero
);

    always_comb begin
        case (aluOp)
            pipePkg::ADD: result = opA + opB;
            pipePkg::SUB: result = opA - opB;
            pipePkg::AND: result = opA & opB;
            pipePkg::OR:  result = opA | opB;
            pipePkg::SLT: begin
                result = isaPkg::word_t'($signed(opA) < $signed(opB));
            end
            // Immediate into the upper half
            pipePkg::LUI: result = {opB[15:0], 16'h0000};
            default:      result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* verilog/decoder.sv */
/*
 * Instruction decoder
 * Produces ALU operation, operand and memory controls, branch flags,
 * extended immediate, destination register and the j target
 */

`include "pipeCpu_defs.svh"

module decoder (
    input  isaPkg::word_t     inst,
    output pipePkg::decoded_t dec,
    output isaPkg::word_t     extImm,
    output isaPkg::regIdx_t   destReg,
    output logic              isJump,
    output isaPkg::word_t     jumpTarget
);

    isaPkg::opcode_t opcode;
    isaPkg::funct_t  funct;
    logic [15:0]     imm;

    assign opcode = isaPkg::opcode_t'(inst[`OPC_F]);
    assign funct  = isaPkg::funct_t'(inst[`FUNCT_F]);
    assign imm    = inst[`IMM_F];

    always_comb begin
        dec    = '0;
        isJump = 1'b0;
        case (opcode)
            isaPkg::RTYPE: begin
                dec.regWrite = 1'b1;
                case (funct)
                    isaPkg::ADDU: dec.aluOp = pipePkg::ADD;
                    isaPkg::SUBU: dec.aluOp = pipePkg::SUB;
                    isaPkg::AND:  dec.aluOp = pipePkg::AND;
                    isaPkg::OR:   dec.aluOp = pipePkg::OR;
                    isaPkg::SLT:  dec.aluOp = pipePkg::SLT;
                    isaPkg::JR: begin
                        dec.isJr     = 1'b1;
                        dec.regWrite = 1'b0;
                    end
                    default:      dec.regWrite = 1'b0;
                endcase
            end
            isaPkg::ADDIU, isaPkg::LW, isaPkg::SW: begin
                dec.aluOp    = pipePkg::ADD;
                dec.useImm   = 1'b1;
                dec.memRead  = (opcode == isaPkg::LW);
                dec.memWrite = (opcode == isaPkg::SW);
                dec.regWrite = (opcode != isaPkg::SW);
            end
            isaPkg::ANDI, isaPkg::ORI: begin
                dec.aluOp      = (opcode == isaPkg::ANDI) ? pipePkg::AND : pipePkg::OR;
                dec.useImm     = 1'b1;
                dec.zeroExtImm = 1'b1;
                dec.regWrite   = 1'b1;
            end
            isaPkg::LUI: begin
                dec.aluOp    = pipePkg::LUI;
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
            end
            // Compare by subtraction, zero flag decides in EX
            isaPkg::BEQ, isaPkg::BNE: begin
                dec.aluOp = pipePkg::SUB;
                dec.isBeq = (opcode == isaPkg::BEQ);
                dec.isBne = (opcode == isaPkg::BNE);
            end
            isaPkg::J:     isJump = 1'b1;
            default: ;
        endcase
    end

    assign extImm = dec.zeroExtImm ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    assign destReg = (opcode == isaPkg::RTYPE) ? inst[`RD_F] : inst[`RT_F];

    // Upper four bits come from the fetch PC in the top level
    assign jumpTarget = {4'h0, inst[`JIDX_F], 2'b00};

endmodule

/* verilog/hazardUnit.sv */
/*
 * Hazard unit
 * Forwarding selects for the EX operands and the load-use stall
 */

module hazardUnit (
    input  isaPkg::regIdx_t  idRs,
    input  isaPkg::regIdx_t  idRt,
    input  isaPkg::regIdx_t  exRs,
    input  isaPkg::regIdx_t  exRt,
    input  isaPkg::regIdx_t  exDest,
    input  isaPkg::regIdx_t  memDest,
    input  isaPkg::regIdx_t  wbDest,
    input  logic             exMemRead,
    input  logic             memRegWrite,
    input  logic             wbRegWrite,
    output pipePkg::fwdSel_t rsFwd,
    output pipePkg::fwdSel_t rtFwd,
    output logic             stall
);

    // Youngest producer wins
    function automatic pipePkg::fwdSel_t pickSource(isaPkg::regIdx_t src);
        if (src == '0) begin
            return pipePkg::NONE;
        end
        if (memRegWrite && memDest == src) begin
            return pipePkg::MEM;
        end
        if (wbRegWrite && wbDest == src) begin
            return pipePkg::WB;
        end
        return pipePkg::NONE;
    endfunction

    assign rsFwd = pickSource(exRs);
    assign rtFwd = pickSource(exRt);

    // Load data is not ready until WB, so hold ID one cycle
    assign stall = exMemRead && exDest != '0 && (exDest == idRs || exDest == idRt);

endmodule

/* verilog/isaPkg.sv */
/*
 * MIPS instruction encoding types
 * Data word, register index, and the opcodes and functs the core decodes
 */

`include "pipeCpu_defs.svh"

package isaPkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`REG_W-1:0]  regIdx_t;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDIU = 6'h09,
        ANDI  = 6'h0c,
        ORI   = 6'h0d,
        LUI   = 6'h0f,
        LW    = 6'h23,
        SW    = 6'h2b
    } opcode_t;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        JR   = 6'h08,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } funct_t;

endpackage

/* verilog/pipeCpu.sv */
/*
 * Five-stage pipelined MIPS core
 * IF, ID, EX, MEM and WB with forwarding, load-use stall and branch flush;
 * instruction and data memories sit outside and answer combinationally
 */

`include "pipeCpu_defs.svh"

module pipeCpu (
    input  logic          clk,
    input  logic          arstN,

    output isaPkg::word_t pc,
    input  isaPkg::word_t inst,

    output isaPkg::word_t dataAddress,
    output isaPkg::word_t writeData,
    output logic          memRead,
    output logic          memWrite,
    input  isaPkg::word_t readData
);

    pipePkg::idPayload_t  ifPl;
    pipePkg::idPayload_t  idPl;
    pipePkg::exPayload_t  idExIn;
    pipePkg::exPayload_t  exPl;
    pipePkg::memPayload_t exMemIn;
    pipePkg::memPayload_t memPl;
    pipePkg::wbPayload_t  memWbIn;
    pipePkg::wbPayload_t  wbPl;

    isaPkg::word_t     pcNext;
    isaPkg::word_t     pcPlus4;
    logic              stall;
    logic              idFlush;
    logic              exFlush;

    pipePkg::decoded_t idDec;
    isaPkg::word_t     idExtImm;
    isaPkg::regIdx_t   idDest;
    logic              idJump;
    isaPkg::word_t     idJumpTarget;
    isaPkg::word_t     idRsVal;
    isaPkg::word_t     idRtVal;

    pipePkg::fwdSel_t  rsFwd;
    pipePkg::fwdSel_t  rtFwd;
    isaPkg::word_t     exRsVal;
    isaPkg::word_t     exRtVal;
    isaPkg::word_t     exAluB;
    isaPkg::word_t     exAluResult;
    logic              exZero;
    logic              exTaken;
    isaPkg::word_t     exTarget;

    isaPkg::word_t     wbValue;

    // ------------------------------------------------------------------------
    // IF
    // ------------------------------------------------------------------------
    assign pcPlus4 = pc + 32'd4;

    // Priority: EX redirect, then j in ID, then stall hold
    always_comb begin
        if (exTaken) begin
            pcNext = exTarget;
        end else if (idJump) begin
            pcNext = {idPl.nextPc[31:28], 28'h0} | idJumpTarget;
        end else if (stall) begin
            pcNext = pc;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign ifPl    = '{nextPc: pcPlus4, inst: inst};
    assign idFlush = exTaken | idJump;

    stageReg #(.payload_t(pipePkg::idPayload_t)) ifIdReg (
        .clk   (clk),
        .arstN (arstN),
        .stall (stall),
        .flush (idFlush),
        .d     (ifPl),
        .q     (idPl)
    );

    // ------------------------------------------------------------------------
    // ID
    // ------------------------------------------------------------------------
    decoder idDecoder (
        .inst       (idPl.inst),
        .dec        (idDec),
        .extImm     (idExtImm),
        .destReg    (idDest),
        .isJump     (idJump),
        .jumpTarget (idJumpTarget)
    );

    regFile regs (
        .clk         (clk),
        .arstN       (arstN),
        .readReg1    (idPl.inst[`RS_F]),
        .readReg2    (idPl.inst[`RT_F]),
        .writeReg    (wbPl.dest),
        .writeEnable (wbPl.regWrite),
        .writeData   (wbValue),
        .readData1   (idRsVal),
        .readData2   (idRtVal)
    );

    hazardUnit hazards (
        .idRs        (idPl.inst[`RS_F]),
        .idRt        (idPl.inst[`RT_F]),
        .exRs        (exPl.rs),
        .exRt        (exPl.rt),
        .exDest      (exPl.dest),
        .memDest     (memPl.dest),
        .wbDest      (wbPl.dest),
        .exMemRead   (exPl.ctl.memRead),
        .memRegWrite (memPl.regWrite),
        .wbRegWrite  (wbPl.regWrite),
        .rsFwd       (rsFwd),
        .rtFwd       (rtFwd),
        .stall       (stall)
    );

    assign idExIn = '{
        nextPc: idPl.nextPc,
        rs:     idPl.inst[`RS_F],
        rt:     idPl.inst[`RT_F],
        rsVal:  idRsVal,
        rtVal:  idRtVal,
        extImm: idExtImm,
        ctl:    idDec,
        dest:   idDest
    };

    // Stall turns the EX slot into a bubble
    assign exFlush = exTaken | stall;

    stageReg #(.payload_t(pipePkg::exPayload_t)) idExReg (
        .clk   (clk),
        .arstN (arstN),
        .stall (1'b0),
        .flush (exFlush),
        .d     (idExIn),
        .q     (exPl)
    );

    // ------------------------------------------------------------------------
    // EX
    // ------------------------------------------------------------------------
    function automatic isaPkg::word_t fwdMux(pipePkg::fwdSel_t sel, isaPkg::word_t regVal);
        case (sel)
            pipePkg::MEM: return memPl.aluResult;
            pipePkg::WB:  return wbValue;
            default:      return regVal;
        endcase
    endfunction

    assign exRsVal = fwdMux(rsFwd, exPl.rsVal);
    assign exRtVal = fwdMux(rtFwd, exPl.rtVal);
    assign exAluB  = exPl.ctl.useImm ? exPl.extImm : exRtVal;

    alu exAlu (
        .opA    (exRsVal),
        .opB    (exAluB),
        .aluOp  (exPl.ctl.aluOp),
        .result (exAluResult),
        .zero   (exZero)
    );

    assign exTaken = (exPl.ctl.isBeq && exZero) || (exPl.ctl.isBne && !exZero) || exPl.ctl.isJr;
    assign exTarget = exPl.ctl.isJr ? exRsVal : exPl.nextPc + (exPl.extImm << 2);

    assign exMemIn = '{
        aluResult: exAluResult,
        storeData: exRtVal,
        dest:      exPl.dest,
        regWrite:  exPl.ctl.regWrite,
        memRead:   exPl.ctl.memRead,
        memWrite:  exPl.ctl.memWrite
    };

    stageReg #(.payload_t(pipePkg::memPayload_t)) exMemReg (
        .clk   (clk),
        .arstN (arstN),
        .stall (1'b0),
        .flush (1'b0),
        .d     (exMemIn),
        .q     (memPl)
    );

    // ------------------------------------------------------------------------
    // MEM
    // ------------------------------------------------------------------------
    assign dataAddress = memPl.aluResult;
    assign writeData   = memPl.storeData;
    assign memRead     = memPl.memRead;
    assign memWrite    = memPl.memWrite;

    assign memWbIn = '{
        fromLoad:  memPl.memRead,
        aluResult: memPl.aluResult,
        loadData:  readData,
        dest:      memPl.dest,
        regWrite:  memPl.regWrite
    };

    stageReg #(.payload_t(pipePkg::wbPayload_t)) memWbReg (
        .clk   (clk),
        .arstN (arstN),
        .stall (1'b0),
        .flush (1'b0),
        .d     (memWbIn),
        .q     (wbPl)
    );

    // ------------------------------------------------------------------------
    // WB
    // ------------------------------------------------------------------------
    assign wbValue = wbPl.fromLoad ? wbPl.loadData : wbPl.aluResult;

endmodule

/* verilog/pipeCpu_defs.svh */
/*
 * Pipelined MIPS core definitions
 * Data and register-index widths, reset PC and instruction field ranges
 */

`ifndef PIPE_CPU_DEFS_SVH
`define PIPE_CPU_DEFS_SVH

// Widths
`define WORD_W   32
`define REG_W    5

// Fetch starts here after reset
`define RESET_PC 32'h0000_0000

// Instruction fields
`define OPC_F    31:26
`define RS_F     25:21
`define RT_F     20:16
`define RD_F     15:11
`define FUNCT_F  5:0
`define IMM_F    15:0

// j target index
`define JIDX_F   25:0

`endif

/* verilog/pipePkg.sv */
/*
 * Pipeline-internal types
 * ALU operation, forwarding select and the payload of each stage register
 */

package pipePkg;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT, LUI} aluOp_t;

    // Source of an EX operand
    typedef enum logic [1:0] {NONE, MEM, WB} fwdSel_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic   useImm;
        logic   zeroExtImm;
        logic   memRead;
        logic   memWrite;
        logic   isBeq;
        logic   isBne;
        logic   isJr;
        logic   regWrite;
    } decoded_t;

    // IF/ID
    typedef struct packed {
        isaPkg::word_t nextPc;
        isaPkg::word_t inst;
    } idPayload_t;

    // ID/EX
    typedef struct packed {
        isaPkg::word_t   nextPc;
        isaPkg::regIdx_t rs;
        isaPkg::regIdx_t rt;
        isaPkg::word_t   rsVal;
        isaPkg::word_t   rtVal;
        isaPkg::word_t   extImm;
        decoded_t        ctl;
        isaPkg::regIdx_t dest;
    } exPayload_t;

    // EX/MEM
    typedef struct packed {
        isaPkg::word_t   aluResult;
        isaPkg::word_t   storeData;
        isaPkg::regIdx_t dest;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
    } memPayload_t;

    // MEM/WB
    typedef struct packed {
        logic            fromLoad;
        isaPkg::word_t   aluResult;
        isaPkg::word_t   loadData;
        isaPkg::regIdx_t dest;
        logic            regWrite;
    } wbPayload_t;

endpackage

/* verilog/regFile.sv */
/*
 * 32 x 32 register file
 * Register 0 reads as zero, a same-cycle write is bypassed to both read ports
 */

module regFile (
    input  logic            clk,
    input  logic            arstN,
    input  isaPkg::regIdx_t readReg1,
    input  isaPkg::regIdx_t readReg2,
    input  isaPkg::regIdx_t writeReg,
    input  logic            writeEnable,
    input  isaPkg::word_t   writeData,
    output isaPkg::word_t   readData1,
    output isaPkg::word_t   readData2
);

    isaPkg::word_t regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeReg != '0) begin
            regs[writeReg] <= writeData;
        end
    end

    function automatic isaPkg::word_t readPort(isaPkg::regIdx_t idx);
        if (idx == '0) begin
            return '0;
        end
        // WB result visible to ID in the same cycle
        if (writeEnable && idx == writeReg) begin
            return writeData;
        end
        return regs[idx];
    endfunction

    assign readData1 = readPort(readReg1);
    assign readData2 = readPort(readReg2);

endmodule

/* verilog/stageReg.sv */
/*
 * Generic pipeline stage register
 * Holds its payload on stall, loads an all-zero bubble on flush
 */

module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush beats stall so a held slot can still be killed
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule
